// File: hdl/draw_defines.svh
/*
 * framebuffer size, coordinate and colour-index widths, segment slot count
 */
`ifndef DRAW_DEFINES_SVH
`define DRAW_DEFINES_SVH

// framebuffer geometry in pixels
`define FB_WIDTH   64
`define FB_HEIGHT  32

// signed coordinate width
`define CORDW      8

// colour index width
`define CIDXW      4

// number of stored line segments
`define LINE_SLOTS 8

`endif

// File: hdl/draw_pkg.sv
/*
 * shared types: segment, pixel write, configuration write, pixel read request
 */
`include "draw_defines.svh"

package draw_pkg;

    typedef struct packed {
        logic signed [`CORDW-1:0] x0;  // start point
        logic signed [`CORDW-1:0] y0;
        logic signed [`CORDW-1:0] x1;  // end point
        logic signed [`CORDW-1:0] y1;
        logic [`CIDXW-1:0]        cidx;
    } line_t;

    typedef struct packed {
        logic signed [`CORDW-1:0] x;
        logic signed [`CORDW-1:0] y;
        logic [`CIDXW-1:0]        cidx;
    } pixel_t;

    typedef enum logic [1:0] {
        CFG_SLOT  = 2'd0,  // seg goes into slot
        CFG_COUNT = 2'd1,  // value is the line count
        CFG_BG    = 2'd2   // value is the background colour
    } cfg_kind_t;

    typedef struct packed {
        cfg_kind_t  kind;
        logic [2:0] slot;
        line_t      seg;
        logic [3:0] value;
    } cfg_wr_t;

    typedef struct packed {
        logic signed [`CORDW-1:0] x;
        logic signed [`CORDW-1:0] y;
    } rd_req_t;

endpackage

// File: hdl/line_list_regs.sv
/*
 * segment slot registers, line count and background colour
 * with a four-phase req/ack write port
 */
`timescale 1ns/1ps
`include "draw_defines.svh"

module line_list_regs import draw_pkg::*; (
    input  logic       clk_100m,
    input  logic       rst_n,
    input  logic       cfg_req,
    input  cfg_wr_t    cfg_wr,
    output logic       cfg_ack,
    input  logic       busy,
    input  logic [2:0] slot_sel,
    output line_t      slot_line,
    output logic [3:0] line_count,
    output logic [3:0] bg_cidx
);

    localparam logic [3:0] MAX_CNT = 4'(`LINE_SLOTS);

    line_t slots [`LINE_SLOTS];
    logic  wr_take;

    // new request, accepted only when no job holds the slots
    assign wr_take = cfg_req && !cfg_ack && !busy;

    always_ff @(posedge clk_100m or negedge rst_n) begin
        if (!rst_n) begin
            cfg_ack    <= 1'b0;
            line_count <= '0;
            bg_cidx    <= '0;
        end else begin
            if (cfg_req && !cfg_ack) begin
                cfg_ack <= 1'b1;  // acked even while busy
            end else if (!cfg_req) begin
                cfg_ack <= 1'b0;
            end
            if (wr_take && cfg_wr.kind == CFG_COUNT) begin
                // more lines than slots makes no sense
                line_count <= (cfg_wr.value > MAX_CNT) ? MAX_CNT : cfg_wr.value;
            end
            if (wr_take && cfg_wr.kind == CFG_BG) begin
                bg_cidx <= cfg_wr.value;
            end
        end
    end

    always_ff @(posedge clk_100m) begin
        if (wr_take && cfg_wr.kind == CFG_SLOT) begin
            slots[cfg_wr.slot] <= cfg_wr.seg;
        end
    end

    assign slot_line = slots[slot_sel];  // read by the sequencer

endmodule

// File: hdl/shape_sequencer.sv
/*
 * job FSM: clears the framebuffer, then feeds each stored segment
 * to the line drawer and forwards its pixels
 */
`timescale 1ns/1ps
`include "draw_defines.svh"

module shape_sequencer import draw_pkg::*; (
    input  logic       clk_100m,
    input  logic       rst_n,
    input  logic       start,
    input  logic [3:0] line_count,
    input  logic [3:0] bg_cidx,
    input  line_t      slot_line,
    output logic [2:0] slot_sel,
    output logic       line_start,
    output line_t      line_out,
    input  logic       line_done,
    input  pixel_t     draw_pix,
    input  logic       draw_valid,
    output pixel_t     fb_pix,
    output logic       fb_we,
    output logic       busy,
    output logic       done
);

    localparam int CW = `CORDW;
    localparam int XW = $clog2(`FB_WIDTH);
    localparam int YW = $clog2(`FB_HEIGHT);
    localparam int AW = XW + YW;
    localparam logic [AW-1:0] CLR_LAST = AW'(`FB_WIDTH * `FB_HEIGHT - 1);

    typedef enum logic [2:0] {IDLE, CLEAR, LOAD, DRAW, FINISH} state_t;

    state_t        state;
    logic [AW-1:0] clr_cnt;   // raster address during clear
    logic [2:0]    slot_idx;
    pixel_t        clr_pix;

    always_ff @(posedge clk_100m or negedge rst_n) begin
        if (!rst_n) begin
            state      <= IDLE;
            clr_cnt    <= '0;
            slot_idx   <= '0;
            line_start <= 1'b0;
            busy       <= 1'b0;
            done       <= 1'b0;
        end else begin
            line_start <= 1'b0;
            done       <= 1'b0;
            case (state)
                CLEAR: begin
                    clr_cnt <= clr_cnt + 1'b1;
                    if (clr_cnt == CLR_LAST) begin
                        slot_idx <= '0;
                        state    <= (line_count == '0) ? FINISH : LOAD;
                    end
                end
                LOAD: begin  // line_out is captured on this edge
                    line_start <= 1'b1;
                    state      <= DRAW;
                end
                DRAW: if (line_done) begin
                    if ({1'b0, slot_idx} == line_count - 4'd1) begin
                        state <= FINISH;
                    end else begin
                        slot_idx <= slot_idx + 1'b1;
                        state    <= LOAD;
                    end
                end
                FINISH: begin
                    busy  <= 1'b0;
                    done  <= 1'b1;
                    state <= IDLE;
                end
                default: if (start) begin  // IDLE
                    busy    <= 1'b1;
                    clr_cnt <= '0;
                    state   <= CLEAR;
                end
            endcase
        end
    end

    always_ff @(posedge clk_100m) begin
        if (state == LOAD) line_out <= slot_line;
    end

    assign slot_sel = slot_idx;

    // raster counter split into x (low bits) and y
    always_comb begin
        clr_pix.x    = CW'(clr_cnt[XW-1:0]);
        clr_pix.y    = CW'(clr_cnt[AW-1:XW]);
        clr_pix.cidx = bg_cidx;
    end

    // clear and draw phases never overlap
    assign fb_we  = (state == CLEAR) || draw_valid;
    assign fb_pix = (state == CLEAR) ? clr_pix : draw_pix;

endmodule

// File: hdl/draw_line.sv
/*
 * Bresenham line rasterizer for all octants, one pixel per cycle
 */
`timescale 1ns/1ps
`include "draw_defines.svh"

module draw_line import draw_pkg::*; (
    input  logic   clk_100m,
    input  logic   rst_n,
    input  logic   line_start,
    input  line_t  line_in,
    output pixel_t pix,
    output logic   pix_valid,
    output logic   line_done
);

    localparam int CW = `CORDW;
    localparam int DW = CW + 3;  // error term width, room for 2*err
    localparam logic signed [CW-1:0] ONE = 1;

    logic signed [CW-1:0] x, y;      // current pixel
    logic signed [CW-1:0] xe, ye;    // end point
    logic [`CIDXW-1:0]    cidx;
    logic signed [DW-1:0] dx, dy;    // dy kept negative
    logic signed [DW-1:0] err, err_nx;
    logic signed [DW:0]   e2;
    logic                 right, down;
    logic                 drawing;
    logic                 at_end;
    logic                 step_x, step_y;
    logic signed [CW:0]   adx, ady;  // raw deltas of the incoming segment
    logic signed [CW:0]   mdx, mdy;  // their magnitudes

    always_comb begin
        adx = {line_in.x1[CW-1], line_in.x1} - {line_in.x0[CW-1], line_in.x0};
        ady = {line_in.y1[CW-1], line_in.y1} - {line_in.y0[CW-1], line_in.y0};
        mdx = adx[CW] ? -adx : adx;
        mdy = ady[CW] ? -ady : ady;
    end

    always_comb begin
        e2     = {err, 1'b0};
        step_x = (e2 >= dy);
        step_y = (e2 <= dx);
        err_nx = err;
        if (step_x) err_nx = err_nx + dy;
        if (step_y) err_nx = err_nx + dx;
    end

    assign at_end = (x == xe) && (y == ye);

    always_ff @(posedge clk_100m or negedge rst_n) begin
        if (!rst_n) begin
            drawing <= 1'b0;
        end else if (line_start) begin
            drawing <= 1'b1;
        end else if (drawing && at_end) begin
            drawing <= 1'b0;  // last pixel goes out this cycle
        end
    end

    always_ff @(posedge clk_100m) begin
        if (line_start) begin
            x     <= line_in.x0;
            y     <= line_in.y0;
            xe    <= line_in.x1;
            ye    <= line_in.y1;
            cidx  <= line_in.cidx;
            right <= (line_in.x0 < line_in.x1);
            down  <= (line_in.y0 < line_in.y1);
            dx    <= DW'(mdx);
            dy    <= -DW'(mdy);
            err   <= DW'(mdx) - DW'(mdy);
        end else if (drawing && !at_end) begin
            if (step_x) x <= right ? x + ONE : x - ONE;
            if (step_y) y <= down ? y + ONE : y - ONE;
            err <= err_nx;
        end
    end

    always_comb begin
        pix.x    = x;
        pix.y    = y;
        pix.cidx = cidx;
    end

    assign pix_valid = drawing;
    assign line_done = drawing && at_end;

endmodule

// File: hdl/framebuffer.sv
/*
 * colour-index framebuffer with a drawing write port
 * and a four-phase req/ack read port
 */
`timescale 1ns/1ps
`include "draw_defines.svh"

module framebuffer import draw_pkg::*; (
    input  logic              clk_100m,
    input  logic              rst_n,
    input  pixel_t            wr_pix,
    input  logic              we,
    input  logic              rd_req,
    input  rd_req_t           rd_addr,
    output logic              rd_ack,
    output logic [`CIDXW-1:0] rd_cidx
);

    localparam int CW    = `CORDW;
    localparam int XW    = $clog2(`FB_WIDTH);
    localparam int YW    = $clog2(`FB_HEIGHT);
    localparam int DEPTH = `FB_WIDTH * `FB_HEIGHT;
    localparam logic [CW-1:0] XLIM = CW'(`FB_WIDTH);
    localparam logic [CW-1:0] YLIM = CW'(`FB_HEIGHT);

    logic [`CIDXW-1:0] mem [DEPTH];
    logic [XW+YW-1:0]  wr_a, rd_a;
    logic              wr_in, rd_in;
    logic              rd_take;

    // negative coordinates read as large unsigned values, so one compare each
    assign wr_in = ($unsigned(wr_pix.x) < XLIM) && ($unsigned(wr_pix.y) < YLIM);
    assign rd_in = ($unsigned(rd_addr.x) < XLIM) && ($unsigned(rd_addr.y) < YLIM);

    assign wr_a = {wr_pix.y[YW-1:0], wr_pix.x[XW-1:0]};  // raster order
    assign rd_a = {rd_addr.y[YW-1:0], rd_addr.x[XW-1:0]};

    assign rd_take = rd_req && !rd_ack;

    always_ff @(posedge clk_100m) begin
        if (we && wr_in) mem[wr_a] <= wr_pix.cidx;
        if (rd_take) rd_cidx <= rd_in ? mem[rd_a] : '0;  // outside reads as 0
    end

    always_ff @(posedge clk_100m or negedge rst_n) begin
        if (!rst_n) begin
            rd_ack <= 1'b0;
        end else if (rd_take) begin
            rd_ack <= 1'b1;
        end else if (!rd_req) begin
            rd_ack <= 1'b0;
        end
    end

endmodule

// File: hdl/draw_top.sv
/*
 * line-drawing engine top: registers, sequencer, line drawer, framebuffer
 */
`timescale 1ns/1ps
`include "draw_defines.svh"

module draw_top import draw_pkg::*; (
    input  logic              clk_100m,
    input  logic              rst_n,
    input  logic              cfg_req,
    input  cfg_wr_t           cfg_wr,
    output logic              cfg_ack,
    input  logic              start,
    output logic              busy,
    output logic              done,
    input  logic              rd_req,
    input  rd_req_t           rd_addr,
    output logic              rd_ack,
    output logic [`CIDXW-1:0] rd_cidx
);

    logic [2:0] slot_sel;
    line_t      slot_line;
    logic [3:0] line_count;
    logic [3:0] bg_cidx;
    logic       line_start, line_done;
    line_t      line_seg;
    pixel_t     draw_pix, fb_pix;
    logic       draw_valid, fb_we;

    line_list_regs regs0 (
        .clk_100m,
        .rst_n,
        .cfg_req,
        .cfg_wr,
        .cfg_ack,
        .busy,
        .slot_sel,
        .slot_line,
        .line_count,
        .bg_cidx
    );

    shape_sequencer seq0 (
        .clk_100m,
        .rst_n,
        .start,
        .line_count,
        .bg_cidx,
        .slot_line,
        .slot_sel,
        .line_start,
        .line_out  (line_seg),
        .line_done,
        .draw_pix,
        .draw_valid,
        .fb_pix,
        .fb_we,
        .busy,
        .done
    );

    draw_line line0 (
        .clk_100m,
        .rst_n,
        .line_start,
        .line_in   (line_seg),
        .pix       (draw_pix),
        .pix_valid (draw_valid),
        .line_done
    );

    framebuffer fb0 (
        .clk_100m,
        .rst_n,
        .wr_pix (fb_pix),
        .we     (fb_we),
        .rd_req,
        .rd_addr,
        .rd_ack,
        .rd_cidx
    );

endmodule

// File: dv/draw_tb.sv
/*
 * testbench for the line-drawing engine: segment and expected-pixel tables,
 * reference Bresenham image, req/ack helpers and compare tasks
 */
`timescale 1ns/1ps
`include "draw_defines.svh"

module draw_tb import draw_pkg::*; ();

    localparam int CW = `CORDW;
    localparam int NPIX = `FB_WIDTH * `FB_HEIGHT;
    localparam int AW = $clog2(NPIX);

    logic              clk_100m;
    logic              rst_n;
    logic              cfg_req;
    cfg_wr_t           cfg_wr;
    logic              cfg_ack;
    logic              start;
    logic              busy;
    logic              done;
    logic              rd_req;
    rd_req_t           rd_addr;
    logic              rd_ack;
    logic [`CIDXW-1:0] rd_cidx;

    // segment table, each entry tagged with its job
    line_t             seg_q[$];
    int                seg_job_q[$];

    // expected-pixel table
    string             exp_name[$];
    int                exp_job[$];
    int                exp_x[$];
    int                exp_y[$];
    logic [`CIDXW-1:0] exp_c[$];

    logic [`CIDXW-1:0] model [NPIX];  // reference image of the current job

    string cur_test;
    int    n_checks, n_errors;
    int    test_checks, test_errors;
    int    cycles, limit;

    draw_top dut0 (.*);

    initial begin
        clk_100m = 1'b0;
        forever #5 clk_100m = ~clk_100m;
    end

    always @(posedge clk_100m) begin
        cycles <= cycles + 1;
        if (limit > 0 && cycles >= limit) begin
            $display("timeout: run stopped after %0d cycles", cycles);
            $display("CHECKS FAILED");
            $finish;
        end
    end

    function automatic line_t mk_line(int x0, int y0, int x1, int y1, int c);
        line_t s;
        s.x0   = CW'(x0);
        s.y0   = CW'(y0);
        s.x1   = CW'(x1);
        s.y1   = CW'(y1);
        s.cidx = 4'(c);
        return s;
    endfunction

    task automatic add_seg(int job, int x0, int y0, int x1, int y1, int c);
        seg_q.push_back(mk_line(x0, y0, x1, y1, c));
        seg_job_q.push_back(job);
    endtask

    task automatic add_exp(string name, int job, int x, int y, int c);
        exp_name.push_back(name);
        exp_job.push_back(job);
        exp_x.push_back(x);
        exp_y.push_back(y);
        exp_c.push_back(4'(c));
    endtask

    function automatic logic [`CIDXW-1:0] job_bg(int job);
        case (job)
            1:       return 4'd3;
            2:       return 4'd0;
            3:       return 4'd1;
            default: return 4'd2;
        endcase
    endfunction

    function automatic string job_name(int job);
        case (job)
            1:       return "clear_only";
            2:       return "straight";
            3:       return "cube";
            default: return "diagonal";
        endcase
    endfunction

    task automatic build_tables();
        // straight segments, two of them reversed
        add_seg(2, 5, 4, 20, 4, 5);
        add_seg(2, 30, 2, 30, 20, 6);
        add_seg(2, 60, 28, 40, 28, 7);
        add_seg(2, 2, 25, 2, 10, 8);
        // cube, front face then back edges and connectors
        add_seg(3, 10, 8, 30, 8, 4);
        add_seg(3, 30, 8, 30, 26, 4);
        add_seg(3, 30, 26, 10, 26, 4);
        add_seg(3, 10, 26, 10, 8, 4);
        add_seg(3, 22, 2, 42, 2, 12);
        add_seg(3, 42, 2, 42, 20, 12);
        add_seg(3, 10, 8, 22, 2, 13);
        add_seg(3, 30, 8, 42, 2, 13);
        // diagonals, reversed, last cube edge and one partly off screen
        add_seg(4, 0, 0, 31, 31, 9);
        add_seg(4, 63, 0, 32, 31, 10);
        add_seg(4, 60, 5, 5, 20, 11);
        add_seg(4, 50, 30, 45, 1, 12);
        add_seg(4, 30, 26, 42, 20, 13);
        add_seg(4, -4, -4, 6, 6, 14);

        add_exp("corner_tl", 1, 0, 0, 3);
        add_exp("corner_tr", 1, 63, 0, 3);
        add_exp("corner_bl", 1, 0, 31, 3);
        add_exp("corner_br", 1, 63, 31, 3);
        add_exp("centre", 1, 32, 16, 3);
        add_exp("h_start", 2, 5, 4, 5);
        add_exp("h_end", 2, 20, 4, 5);
        add_exp("h_before", 2, 4, 4, 0);
        add_exp("h_after", 2, 21, 4, 0);
        add_exp("v_top", 2, 30, 2, 6);
        add_exp("v_bottom", 2, 30, 20, 6);
        add_exp("v_above", 2, 30, 1, 0);
        add_exp("v_below", 2, 30, 21, 0);
        add_exp("h2_start", 2, 60, 28, 7);
        add_exp("h2_past_start", 2, 61, 28, 0);
        add_exp("h2_past_end", 2, 39, 28, 0);
        add_exp("v2_start", 2, 2, 25, 8);
        add_exp("v2_end", 2, 2, 10, 8);
        add_exp("v2_past_start", 2, 2, 26, 0);
        add_exp("v2_past_end", 2, 2, 9, 0);
        add_exp("overlap_origin", 4, 0, 0, 14);  // later slot wins
        add_exp("overlap_mid", 4, 3, 3, 14);
        add_exp("diag_after_overlap", 4, 7, 7, 9);
        add_exp("diag_end", 4, 31, 31, 9);
        add_exp("rev_diag_start", 4, 63, 0, 10);
        add_exp("rev_diag_end", 4, 32, 31, 10);
    endtask

    function automatic int seg_len(line_t s);
        int dx, dy;
        dx = int'($signed(s.x1)) - int'($signed(s.x0));
        dy = int'($signed(s.y1)) - int'($signed(s.y0));
        if (dx < 0) dx = -dx;
        if (dy < 0) dy = -dy;
        return ((dx > dy) ? dx : dy) + 1;
    endfunction

    // clear plus segment pixels of every job, jobs 5 and 6 rerun job 4
    function automatic int timeout_limit();
        int sum;
        sum = 0;
        for (int job = 1; job <= 6; job++) begin
            sum += NPIX;
            for (int i = 0; i < seg_q.size(); i++) begin
                if (seg_job_q[i] == job || (job >= 5 && seg_job_q[i] == 4)) begin
                    sum += seg_len(seg_q[i]);
                end
            end
        end
        return 2 * sum + 1000;
    endfunction

    function automatic logic [AW-1:0] fb_addr(int x, int y);
        return AW'(y * `FB_WIDTH + x);
    endfunction

    task automatic check_cidx(string name, logic [`CIDXW-1:0] exp, logic [`CIDXW-1:0] act);
        n_checks++;
        if (exp !== act) begin
            n_errors++;
            $display("[FAIL] %s %s: expected %0d, actual %0d", cur_test, name, exp, act);
        end
    endtask

    task automatic check_flag(string name, logic exp, logic act);
        n_checks++;
        if (exp !== act) begin
            n_errors++;
            $display("[FAIL] %s %s: expected %0b, actual %0b", cur_test, name, exp, act);
        end
    endtask

    task automatic begin_test(string name);
        cur_test    = name;
        test_checks = n_checks;
        test_errors = n_errors;
    endtask

    task automatic end_test();
        $display("test %s: %0d checks, %0d errors", cur_test,
                 n_checks - test_checks, n_errors - test_errors);
    endtask

    task automatic cfg_write(cfg_wr_t w);
        @(posedge clk_100m);
        cfg_wr  <= w;
        cfg_req <= 1'b1;
        @(negedge clk_100m);
        check_flag("cfg_ack early", 1'b0, cfg_ack);  // no ack in the request cycle
        while (!cfg_ack) @(negedge clk_100m);
        @(posedge clk_100m);
        cfg_req <= 1'b0;
        @(negedge clk_100m);
        check_flag("cfg_ack dropped early", 1'b1, cfg_ack);
        while (cfg_ack) @(negedge clk_100m);
    endtask

    task automatic read_pixel(int x, int y, output logic [`CIDXW-1:0] c);
        rd_req_t a;
        a.x = CW'(x);
        a.y = CW'(y);
        @(posedge clk_100m);
        rd_addr <= a;
        rd_req  <= 1'b1;
        @(negedge clk_100m);
        check_flag("rd_ack early", 1'b0, rd_ack);
        while (!rd_ack) @(negedge clk_100m);
        c = rd_cidx;
        @(posedge clk_100m);
        rd_req <= 1'b0;
        @(negedge clk_100m);
        check_flag("rd_ack dropped early", 1'b1, rd_ack);
        while (rd_ack) @(negedge clk_100m);
    endtask

    task automatic start_job();
        @(posedge clk_100m);
        start <= 1'b1;
        @(posedge clk_100m);
        start <= 1'b0;
        @(negedge clk_100m);
        check_flag("busy after start", 1'b1, busy);
    endtask

    task automatic wait_done();
        while (!done) @(negedge clk_100m);
        check_flag("busy at done", 1'b0, busy);
    endtask

    task automatic configure(int job);
        cfg_wr_t w;
        int      n;
        n = 0;
        w = '0;
        w.kind  = CFG_BG;
        w.value = job_bg(job);
        cfg_write(w);
        for (int i = 0; i < seg_q.size(); i++) begin
            if (seg_job_q[i] == job) begin
                w = '0;
                w.kind = CFG_SLOT;
                w.slot = 3'(n);
                w.seg  = seg_q[i];
                cfg_write(w);
                n++;
            end
        end
        w = '0;
        w.kind  = CFG_COUNT;
        w.value = 4'(n);
        cfg_write(w);
    endtask

    // integer Bresenham, either paints the model or compares the DUT with it
    task automatic walk_line(line_t s, bit chk, string name);
        int                x, y, x1, y1, dx, dy, sx, sy, err, e2;
        bit                fin;
        logic [`CIDXW-1:0] got;
        x   = int'($signed(s.x0));
        y   = int'($signed(s.y0));
        x1  = int'($signed(s.x1));
        y1  = int'($signed(s.y1));
        dx  = (x1 > x) ? x1 - x : x - x1;
        dy  = (y1 > y) ? y - y1 : y1 - y;  // negative
        sx  = (x < x1) ? 1 : -1;
        sy  = (y < y1) ? 1 : -1;
        err = dx + dy;
        fin = 1'b0;
        while (!fin) begin
            if (x >= 0 && x < `FB_WIDTH && y >= 0 && y < `FB_HEIGHT) begin
                if (chk) begin
                    read_pixel(x, y, got);
                    check_cidx($sformatf("%s (%0d,%0d)", name, x, y), model[fb_addr(x, y)], got);
                end else begin
                    model[fb_addr(x, y)] = s.cidx;
                end
            end
            if (x == x1 && y == y1) begin
                fin = 1'b1;
            end else begin
                e2 = 2 * err;
                if (e2 >= dy) begin
                    err += dy;
                    x   += sx;
                end
                if (e2 <= dx) begin
                    err += dx;
                    y   += sy;
                end
            end
        end
    endtask

    task automatic build_model(int job);
        for (int a = 0; a < NPIX; a++) model[AW'(a)] = job_bg(job);
        for (int i = 0; i < seg_q.size(); i++) begin
            if (seg_job_q[i] == job) walk_line(seg_q[i], 1'b0, "");
        end
    endtask

    task automatic check_table(int job);
        logic [`CIDXW-1:0] got;
        for (int i = 0; i < exp_name.size(); i++) begin
            if (exp_job[i] == job) begin
                read_pixel(exp_x[i], exp_y[i], got);
                check_cidx(exp_name[i], exp_c[i], got);
            end
        end
    endtask

    task automatic check_segments(int job);
        for (int i = 0; i < seg_q.size(); i++) begin
            if (seg_job_q[i] == job) walk_line(seg_q[i], 1'b1, $sformatf("seg%0d", i));
        end
    endtask

    initial begin
        cfg_wr_t w;
        line_t   ignored;
        n_checks = 0;
        n_errors = 0;
        cycles   = 0;
        limit    = 0;
        rst_n    <= 1'b0;
        cfg_req  <= 1'b0;
        cfg_wr   <= '0;
        start    <= 1'b0;
        rd_req   <= 1'b0;
        rd_addr  <= '0;
        build_tables();
        limit = timeout_limit();
        repeat (5) @(posedge clk_100m);
        rst_n <= 1'b1;
        @(negedge clk_100m);

        begin_test("reset");
        check_flag("cfg_ack", 1'b0, cfg_ack);
        check_flag("rd_ack", 1'b0, rd_ack);
        check_flag("busy", 1'b0, busy);
        check_flag("done", 1'b0, done);
        end_test();

        for (int job = 1; job <= 4; job++) begin
            begin_test(job_name(job));
            configure(job);
            build_model(job);
            start_job();
            wait_done();
            check_table(job);
            check_segments(job);
            end_test();
        end

        // rerun of the diagonal job with writes thrown at it mid-job
        begin_test("busy_write");
        ignored = mk_line(0, 31, 63, 31, 15);
        build_model(4);
        start_job();
        w = '0;
        w.kind = CFG_SLOT;
        w.slot = 3'd0;
        w.seg  = ignored;
        cfg_write(w);
        check_flag("busy during write", 1'b1, busy);
        w = '0;
        w.kind  = CFG_BG;
        w.value = 4'd7;
        cfg_write(w);
        w = '0;
        w.kind  = CFG_COUNT;
        w.value = 4'd1;
        cfg_write(w);
        wait_done();
        start_job();  // second run uses whatever the slots hold now
        wait_done();
        check_table(4);
        check_segments(4);
        walk_line(ignored, 1'b1, "ignored_seg");
        end_test();

        $display("checks: %0d, errors: %0d", n_checks, n_errors);
        if (n_errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

// File: verilog.f
+incdir+hdl
hdl/draw_pkg.sv
hdl/line_list_regs.sv
hdl/shape_sequencer.sv
hdl/draw_line.sv
hdl/framebuffer.sv
hdl/draw_top.sv
dv/draw_tb.sv

// File: run_sim.sh
#!/bin/sh
# build the line-drawing testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -j 0 -f verilog.f --top-module draw_tb -o draw_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

out=$(./obj_dir/draw_sim)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$out" | grep -qx "ALL CHECKS PASSED"; then
    exit 0
fi
echo "pass message not found in simulation output"
exit 1
